// File: Bender.yml
package:
  name: neuralLayer

sources:
  - common/layerPkg.sv
  - common/neuronPkg.sv
  - common/operandIf.sv
  - hiddenLayer/neuron.sv
  - logic/operandFeeder.sv
  - logic/resultDrain.sv
  - logic/hiddenLayerTop.sv
  - target: test
    files:
      - verif/layerTb.sv

// File: common/layerPkg.sv
package layerPkg;

    //////////////////////////////////////////////////
    // Layer geometry
    //////////////////////////////////////////////////

    // Neurons in the hidden layer
    localparam int NumNeurons = 4;

    // Pixels in one image
    localparam int NumInputs = 16;

    //////////////////////////////////////////////////
    // Index widths
    //////////////////////////////////////////////////

    localparam int NeuronIdxW = 2;
    localparam int InputIdxW = 4;

endpackage

// File: common/neuronPkg.sv
package neuronPkg;

    //////////////////////////////////////////////////
    // Numeric formats
    //////////////////////////////////////////////////

    typedef logic        [7:0]  pixelT;
    typedef logic signed [15:0] weightT;
    // 9-bit zero-extended pixel times 16-bit weight
    typedef logic signed [24:0] productT;
    typedef logic signed [31:0] accumT;
    // Same format as a pixel of the next layer
    typedef logic        [7:0]  activT;

    //////////////////////////////////////////////////
    // Activation scaling
    //////////////////////////////////////////////////

    localparam int ActShift = 6;
    localparam int ActMax = 255;
endpackage

// File: common/operandIf.sv
`timescale 1ns/1ps

// Pixel broadcast from the feeder to every neuron
interface operandIf import layerPkg::*, neuronPkg::*; ();

    logic   opValid;
    // Marks the final pixel of an image
    logic   opLast;
    pixelT  opPixel;
    // One weight per neuron for the current pixel
    weightT opWeight [NumNeurons];

    modport source (
        output opValid,
        output opLast,
        output opPixel,
        output opWeight
    );

    modport sink (
        input opValid,
        input opLast,
        input opPixel,
        input opWeight
    );
endinterface

// File: hiddenLayer/neuron.sv
`timescale 1ns/1ps

module neuron import neuronPkg::*; (
    input  logic   Clk,
    input  logic   reset,
    operandIf.sink op,
    input  weightT weight,
    output logic   sumValid,
    output accumT  sum
);

    productT product;
    logic    prodValid;
    logic    prodLast;
    accumT   accum;
    accumT   accumNext;

    //////////////////////////////////////////////////
    // Multiply stage
    //////////////////////////////////////////////////

    // Leading zero keeps the pixel positive in signed math
    always_ff @(posedge Clk) begin
        product  <= $signed({1'b0, op.opPixel}) * weight;
        prodLast <= op.opLast;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= op.opValid;
        end
    end

    //////////////////////////////////////////////////
    // Accumulate stage
    //////////////////////////////////////////////////

    assign accumNext = accum + product;

    always_ff @(posedge Clk) begin
        if (reset) begin
            accum    <= '0;
            sumValid <= 1'b0;
        end else begin
            sumValid <= prodValid && prodLast;
            if (prodValid) begin
                // Restart at zero so the next image can follow directly
                accum <= prodLast ? '0 : accumNext;
            end
        end
    end

    // Total for the finished image
    always_ff @(posedge Clk) begin
        if (prodValid && prodLast) begin
            sum <= accumNext;
        end
    end

endmodule

// File: logic/hiddenLayerTop.sv
`timescale 1ns/1ps

module hiddenLayerTop import layerPkg::*, neuronPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  pixelValid,
    output logic                  pixelReady,
    input  pixelT                 pixelData,
    input  logic                  pixelLast,
    input  logic                  weightWrite,
    input  logic [NeuronIdxW-1:0] weightNeuron,
    input  logic [InputIdxW-1:0]  weightInput,
    input  weightT                weightData,
    output logic                  resultValid,
    input  logic                  resultReady,
    output logic [NeuronIdxW-1:0] resultIndex,
    output activT                 resultData
);

    operandIf opBus ();

    logic [NumNeurons-1:0] sumValid;
    accumT                 sums [NumNeurons];
    logic                  drainBusy;

    operandFeeder uFeeder (
        .Clk, .reset,
        .pixelValid, .pixelReady, .pixelData, .pixelLast,
        .weightWrite, .weightNeuron, .weightInput, .weightData,
        .drainBusy,
        .op (opBus)
    );

    //////////////////////////////////////////////////
    // Neuron array
    //////////////////////////////////////////////////

    for (genvar n = 0; n < NumNeurons; n++) begin : gNeuron
        neuron uNeuron (
            .Clk, .reset,
            .op       (opBus),
            .weight   (opBus.opWeight[n]),
            .sumValid (sumValid[n]),
            .sum      (sums[n])
        );
    end

    resultDrain uDrain (
        .Clk, .reset,
        .sumValid, .sums, .drainBusy,
        .resultValid, .resultReady, .resultIndex, .resultData
    );

endmodule

// File: logic/operandFeeder.sv
`timescale 1ns/1ps

module operandFeeder import layerPkg::*, neuronPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  pixelValid,
    output logic                  pixelReady,
    input  pixelT                 pixelData,
    input  logic                  pixelLast,
    input  logic                  weightWrite,
    input  logic [NeuronIdxW-1:0] weightNeuron,
    input  logic [InputIdxW-1:0]  weightInput,
    input  weightT                weightData,
    input  logic                  drainBusy,
    operandIf.source              op
);

    typedef enum logic [1:0] {
        FeedS,
        WaitS,
        DrainS
    } feedStateT;

    feedStateT              state;
    feedStateT              nextState;
    logic                   accept;
    logic [InputIdxW-1:0]   pixelIdx;
    weightT                 weightMem [NumNeurons][NumInputs];

    assign accept = pixelValid && pixelReady;

    //////////////////////////////////////////////////
    // Weight memory
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (weightWrite) begin
            weightMem[weightNeuron][weightInput] <= weightData;
        end
    end

    //////////////////////////////////////////////////
    // Input flow control
    //////////////////////////////////////////////////

    // Closed after a last pixel until the drain has emptied
    always_comb begin
        nextState = state;
        case (state)
            FeedS:   if (accept && pixelLast) nextState = WaitS;
            WaitS:   if (drainBusy) nextState = DrainS;
            DrainS:  if (!drainBusy) nextState = FeedS;
            default: nextState = FeedS;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state      <= FeedS;
            pixelReady <= 1'b0;
            pixelIdx   <= '0;
            op.opValid <= 1'b0;
        end else begin
            state      <= nextState;
            pixelReady <= (nextState == FeedS);
            op.opValid <= accept;
            if (accept) begin
                pixelIdx <= pixelLast ? '0 : pixelIdx + 1'b1;
            end
        end
    end

    // Pixel and every neuron's weight leave together
    always_ff @(posedge Clk) begin
        if (accept) begin
            op.opPixel <= pixelData;
            op.opLast  <= pixelLast;
            for (int n = 0; n < NumNeurons; n++) begin
                op.opWeight[n] <= weightMem[n][pixelIdx];
            end
        end
    end

endmodule

// File: logic/resultDrain.sv
`timescale 1ns/1ps

module resultDrain import layerPkg::*, neuronPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic [NumNeurons-1:0] sumValid,
    input  accumT                 sums [NumNeurons],
    output logic                  drainBusy,
    output logic                  resultValid,
    input  logic                  resultReady,
    output logic [NeuronIdxW-1:0] resultIndex,
    output activT                 resultData
);

    activT actReg [NumNeurons];
    logic  captureEn;
    logic  lastIndex;

    //////////////////////////////////////////////////
    // Activation
    //////////////////////////////////////////////////

    // ReLU, scale down, then clamp to the pixel range
    function automatic activT activate(input accumT s);
        accumT shifted;
        shifted = s >>> ActShift;
        if (s <= 0) begin
            return '0;
        end else if (shifted > ActMax) begin
            return activT'(ActMax);
        end else begin
            return activT'(shifted);
        end
    endfunction

    // Neurons finish in lockstep
    assign captureEn = &sumValid;
    assign lastIndex = (resultIndex == NeuronIdxW'(NumNeurons - 1));

    always_ff @(posedge Clk) begin
        if (captureEn) begin
            for (int n = 0; n < NumNeurons; n++) begin
                actReg[n] <= activate(sums[n]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Serial output
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            resultIndex <= '0;
        end else if (captureEn) begin
            resultValid <= 1'b1;
            resultIndex <= '0;
        end else if (resultValid && resultReady) begin
            // Index wraps back to zero after the last neuron
            resultIndex <= resultIndex + 1'b1;
            if (lastIndex) begin
                resultValid <= 1'b0;
            end
        end
    end

    assign resultData = actReg[resultIndex];

    // Busy for exactly as long as results are pending
    assign drainBusy = resultValid;

endmodule

// File: neuralLayer.f
common/layerPkg.sv
common/neuronPkg.sv
common/operandIf.sv
hiddenLayer/neuron.sv
logic/operandFeeder.sv
logic/resultDrain.sv
logic/hiddenLayerTop.sv
verif/layerTb.sv

// File: verif/layerTb.sv
`timescale 1ns/1ps

module layerTb import layerPkg::*, neuronPkg::*; ();

    // Five images of about 40 cycles plus weight loading, with margin
    localparam int MaxCycles = 2000;

    logic                  Clk = 1'b0;
    logic                  reset;
    logic                  pixelValid;
    logic                  pixelReady;
    pixelT                 pixelData;
    logic                  pixelLast;
    logic                  weightWrite;
    logic [NeuronIdxW-1:0] weightNeuron;
    logic [InputIdxW-1:0]  weightInput;
    weightT                weightData;
    logic                  resultValid;
    logic                  resultReady;
    logic [NeuronIdxW-1:0] resultIndex;
    activT                 resultData;

    int    weightModel [NumNeurons][NumInputs];
    pixelT image [NumInputs];
    int    expIdx [$];
    int    expData [$];
    int    valueErrs = 0;
    int    otherErrs = 0;
    int    cycles = 0;
    logic  stallOn = 1'b0;

    hiddenLayerTop dut0 (.*);

    initial begin
        forever #50 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // ReLU, scale by 2^ActShift and clamp to ActMax
    function automatic int expectedAct(input longint s);
        longint scaled;
        scaled = s / (longint'(1) << ActShift);
        if (s <= 0) begin
            return 0;
        end else if (scaled > ActMax) begin
            return ActMax;
        end
        return int'(scaled);
    endfunction

    task automatic queueExpected();
        longint s;
        for (int n = 0; n < NumNeurons; n++) begin
            s = 0;
            for (int i = 0; i < NumInputs; i++) begin
                s += longint'(image[i]) * weightModel[n][i];
            end
            expIdx.push_back(n);
            expData.push_back(expectedAct(s));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Weights lo .. lo+span-1 for one neuron
    task automatic loadNeuron(input int n, input int lo, input int span);
        int w;
        for (int i = 0; i < NumInputs; i++) begin
            w = lo + int'($urandom % span);
            weightWrite  = 1'b1;
            weightNeuron = NeuronIdxW'(n);
            weightInput  = InputIdxW'(i);
            weightData   = weightT'(w);
            weightModel[n][i] = w;
            @(negedge Clk);
        end
        weightWrite = 1'b0;
    endtask

    task automatic fillImage(input int lo, input int span);
        for (int i = 0; i < NumInputs; i++) begin
            image[i] = pixelT'(lo + int'($urandom % span));
        end
    endtask

    // pixelReady is registered, so its value at the falling edge decides the transfer
    task automatic sendImage();
        logic taken;
        queueExpected();
        for (int i = 0; i < NumInputs; i++) begin
            pixelValid = 1'b1;
            pixelData  = image[i];
            pixelLast  = (i == NumInputs - 1);
            do begin
                taken = pixelReady;
                @(negedge Clk);
            end while (!taken);
        end
        pixelValid = 1'b0;
        pixelLast  = 1'b0;
    endtask

    task automatic waitDrained();
        while (expIdx.size() != 0 || resultValid) begin
            @(negedge Clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Result checking
    //////////////////////////////////////////////////

    task automatic checkResult();
        int ei;
        int ed;
        if (expIdx.size() == 0) begin
            otherErrs++;
            $display("Unexpected result for neuron %0d at %0t", resultIndex, $time);
        end else begin
            ei = expIdx.pop_front();
            ed = expData.pop_front();
            assert (resultIndex == ei) else begin
                valueErrs++;
                $display("ERR %0t resultIndex expected %0d got %0d", $time, ei, resultIndex);
            end
            assert (resultData == ed) else begin
                valueErrs++;
                $display("ERR %0t resultData expected %0d got %0d", $time, ed, resultData);
            end
        end
    endtask

    // Output consumer with random back-pressure stretches
    initial begin : consumer
        logic                  holdPending;
        logic [NeuronIdxW-1:0] heldIdx;
        activT                 heldData;
        int                    stall;
        holdPending = 1'b0;
        stall = 0;
        resultReady = 1'b1;
        forever begin
            @(negedge Clk);
            if (holdPending) begin
                assert (resultValid) else begin
                    otherErrs++;
                    $display("resultValid dropped before acceptance at %0t", $time);
                end
                assert (resultIndex == heldIdx) else begin
                    valueErrs++;
                    $display("ERR %0t resultIndex expected %0d got %0d",
                             $time, heldIdx, resultIndex);
                end
                assert (resultData == heldData) else begin
                    valueErrs++;
                    $display("ERR %0t resultData expected %0d got %0d",
                             $time, heldData, resultData);
                end
            end
            if (stall > 0) begin
                resultReady = 1'b0;
                stall--;
            end else begin
                resultReady = 1'b1;
                if (stallOn && ($urandom % 3 == 0)) begin
                    stall = 1 + int'($urandom % 6);
                end
            end
            if (resultValid && resultReady) begin
                checkResult();
            end
            holdPending = resultValid && !resultReady;
            heldIdx = resultIndex;
            heldData = resultData;
        end
    end

    // Input stays closed from the last pixel until the first result shows
    assert property (@(posedge Clk) disable iff (reset)
        pixelValid && pixelReady && pixelLast |=>
            !pixelReady ##1 !pixelReady ##1 !pixelReady)
    else begin
        valueErrs++;
        $display("ERR %0t pixelReady expected 0 got 1", $time);
    end

    assert property (@(posedge Clk) disable iff (reset) resultValid |-> !pixelReady)
    else begin
        valueErrs++;
        $display("ERR %0t pixelReady expected 0 got 1 while results are pending", $time);
    end

    // resultValid is set at edge t+3, so it is first sampled high at t+4
    assert property (@(posedge Clk) disable iff (reset)
        pixelValid && pixelReady && pixelLast |=> ##3 $rose(resultValid))
    else begin
        otherErrs++;
        $display("First result did not appear 3 cycles after the last pixel at %0t", $time);
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(47520));
        reset        = 1'b1;
        pixelValid   = 1'b0;
        pixelData    = '0;
        pixelLast    = 1'b0;
        weightWrite  = 1'b0;
        weightNeuron = '0;
        weightInput  = '0;
        weightData   = '0;
        repeat (3) @(negedge Clk);
        assert (!pixelReady) else begin
            valueErrs++;
            $display("ERR %0t pixelReady expected 0 got %0b", $time, pixelReady);
        end
        reset = 1'b0;
        @(negedge Clk);
        assert (pixelReady) else begin
            valueErrs++;
            $display("ERR %0t pixelReady expected 1 got %0b", $time, pixelReady);
        end
        assert (!resultValid) else begin
            valueErrs++;
            $display("ERR %0t resultValid expected 0 got %0b", $time, resultValid);
        end

        // Small weights keep many sums inside the 8-bit range
        for (int n = 0; n < NumNeurons; n++) begin
            loadNeuron(n, -64, 128);
        end
        fillImage(0, 256);
        sendImage();
        fillImage(0, 256);
        sendImage();

        // Neuron 0 negative, 1 saturating, 2 moderate
        waitDrained();
        loadNeuron(0, -1000, 1);
        loadNeuron(1, 32767, 1);
        loadNeuron(2, 3, 1);
        fillImage(200, 1);
        sendImage();

        // Same pixels twice, with only neuron 2 rewritten in between
        waitDrained();
        stallOn = 1'b1;
        fillImage(0, 256);
        sendImage();
        waitDrained();
        loadNeuron(2, -64, 128);
        sendImage();
        waitDrained();
        repeat (4) @(negedge Clk);

        $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
